//--- tb.f
soc_bus_pkg.sv
soc_irq_pkg.sv
wb_bus_if.sv
reset_debounce.sv
wb_switch.sv
base_ram.sv
sw_leds.sv
pit_timer.sv
simple_pic.sv
kotku_lite.sv
tb_kotku.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert -f tb.f --top-module tb_kotku -o tb_kotku &&
./obj_dir/tb_kotku | tee /dev/stderr | grep -q "SIMULATION PASSED" &&
echo "Run passed" ||
{ echo "Run failed"; exit 1; }

//--- tb_kotku.sv
// Testbench for reduced PC fabric
`timescale 1ns/1ns
`default_nettype none

module tb_kotku import soc_bus_pkg::*, soc_irq_pkg::*; ();

  localparam int CLK_HALF   = 50;
  localparam int RST_CYCLES = 8;
  localparam int BUS_WAIT   = 20;  // Cycles before a bus cycle counts as stuck
  localparam int IRQ_WAIT   = 200;
  localparam int RAM_TESTS  = 16;

  logic             clk;
  logic             rst_lck;
  word_addr_t       wb_adr;
  logic             wb_tga;
  data_t            wb_dat_w;
  data_t            wb_dat_r;
  logic [SEL_W-1:0] wb_sel;
  logic             wb_we;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_ack;
  logic [6:0]       irq;
  logic             intr;
  logic             inta;
  logic             nmi;
  logic             nmia;
  logic [7:0]       sw;
  logic             key;
  logic [LED_W-1:0] leds;
  logic             cpu_rst;

  // Reference models
  data_t            ram_model [RAM_WORDS];
  logic [LED_W-1:0] led_model;
  logic [31:0]      seed;
  int               err_cnt;
  int               chk_cnt;

  // Reads waiting for the compare process
  data_t exp_q[$];
  data_t got_q[$];
  string name_q[$];

  kotku_lite dut_i (
    .clk       (clk),
    .rst_lck   (rst_lck),
    .wb_adr_i  (wb_adr),
    .wb_tga_i  (wb_tga),
    .wb_dat_i  (wb_dat_w),
    .wb_dat_o  (wb_dat_r),
    .wb_sel_i  (wb_sel),
    .wb_we_i   (wb_we),
    .wb_cyc_i  (wb_cyc),
    .wb_stb_i  (wb_stb),
    .wb_ack_o  (wb_ack),
    .irq_i     (irq),
    .intr_o    (intr),
    .inta_i    (inta),
    .nmi_o     (nmi),
    .nmia_i    (nmia),
    .sw_i      (sw),
    .key_i     (key),
    .leds_o    (leds),
    .cpu_rst_o (cpu_rst)
  );

  always #(CLK_HALF) clk = ~clk;

  function automatic logic [31:0] lcg();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Same RAM word seen through other upper address bits
  function automatic word_addr_t alias_of(input word_addr_t adr, input logic [31:0] r);
    return adr + word_addr_t'(RAM_WORDS * (r % 512));
  endfunction

  function automatic data_t ref_read(input logic tga, input word_addr_t adr);
    logic [ADDR_W:0] ba;
    ba = {adr, 1'b0};
    if (!tga) return ram_model[int'(adr) % RAM_WORDS];
    if (ba >= 20'hf100 && ba <= 20'hf103) return adr[0] ? data_t'(led_model) : data_t'(sw);
    return '0;  // Unmatched IO, timer words never read here
  endfunction

  task automatic check(input string name, input data_t exp, input data_t got);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL at %0t ns: %s expected %h, got %h", $time, name, exp, got);
    end
  endtask

  task automatic report_timeout(input string why);
    err_cnt++;
    $display("Timeout at %0t ns: %s", $time, why);
  endtask

  task automatic check_reset_state(input logic rst_exp);
    check("cpu_rst_o", data_t'(rst_exp), data_t'(cpu_rst));
    check("wb_ack_o", '0, data_t'(wb_ack));
    check("intr_o", '0, data_t'(intr));
    check("nmi_o", '0, data_t'(nmi));
  endtask

  task automatic bus_cycle(input logic tga, input word_addr_t adr, input logic we,
                           input data_t wdat, input logic [SEL_W-1:0] sel,
                           output data_t rdat);
    int n;
    @(negedge clk);
    wb_tga   = tga;
    wb_adr   = adr;
    wb_we    = we;
    wb_dat_w = wdat;
    wb_sel   = sel;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    n = 0;
    @(negedge clk);
    while (!wb_ack && n < BUS_WAIT) begin
      @(negedge clk);
      n++;
    end
    if (!wb_ack) report_timeout($sformatf("no ack for word address %h", adr));
    rdat = wb_dat_r;
    @(negedge clk);  // Request held through the ack edge
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic model_write(input logic tga, input word_addr_t adr, input data_t data,
                             input logic [SEL_W-1:0] sel);
    int idx;
    idx = int'(adr) % RAM_WORDS;
    if (!tga) begin
      for (int b = 0; b < SEL_W; b++) begin
        if (sel[b]) ram_model[idx][b*8 +: 8] = data[b*8 +: 8];
      end
    end else if ({adr, 1'b0} == 20'hf102) begin
      if (sel[0]) led_model[7:0] = data[7:0];
      if (sel[1]) led_model[LED_W-1:8] = data[LED_W-1:8];
    end
  endtask

  task automatic write_word(input logic tga, input word_addr_t adr, input data_t data,
                            input logic [SEL_W-1:0] sel);
    data_t rd_ignored;
    bus_cycle(tga, adr, 1'b1, data, sel, rd_ignored);
    model_write(tga, adr, data, sel);
  endtask

  task automatic read_check(input logic tga, input word_addr_t adr, input string name);
    data_t exp;
    data_t got;
    exp = ref_read(tga, adr);  // Model state before the read
    bus_cycle(tga, adr, 1'b0, '0, '1, got);
    exp_q.push_back(exp);
    got_q.push_back(got);
    name_q.push_back(name);
  endtask

  task automatic ack_interrupt(output data_t vec);
    @(negedge clk);
    inta = 1'b1;
    #(CLK_HALF / 5);
    vec = wb_dat_r;
    @(negedge clk);
    inta = 1'b0;
  endtask

  // Compare process
  initial begin
    forever begin
      @(negedge clk);
      while (got_q.size() > 0) begin
        check(name_q.pop_front(), exp_q.pop_front(), got_q.pop_front());
      end
    end
  end

  initial begin
    word_addr_t  addrs [RAM_TESTS];
    data_t       v;
    logic [31:0] r;
    int          n;
    clk      = 1'b0;
    rst_lck  = 1'b0;
    wb_adr   = '0;
    wb_tga   = 1'b0;
    wb_dat_w = '0;
    wb_sel   = '0;
    wb_we    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    irq      = '0;
    inta     = 1'b0;
    nmia     = 1'b0;
    sw       = '0;
    key      = 1'b1;  // Button released
    seed     = 32'h2060;
    err_cnt  = 0;
    chk_cnt  = 0;
    led_model = '0;

    // Reset and debounce hold
    for (int i = 0; i < RST_CYCLES; i++) begin
      @(negedge clk);
      if (i > 0) check_reset_state(1'b1);  // Registers settle after the first edge
    end
    rst_lck = 1'b1;
    for (int i = 0; i < DEBOUNCE_CYCLES; i++) begin
      @(negedge clk);
      check_reset_state(1'b1);
    end
    @(negedge clk);
    check_reset_state(1'b0);
    check("leds_o", '0, data_t'(leds));

    // RAM words, then single bytes through aliases
    for (int i = 0; i < RAM_TESTS; i++) begin
      r = lcg();
      addrs[i] = r[ADDR_W-1:0];
      r = lcg();
      write_word(1'b0, addrs[i], r[31:16], 2'b11);
    end
    for (int i = 0; i < RAM_TESTS / 2; i++) begin
      r = lcg();
      write_word(1'b0, alias_of(addrs[r[27:24]], r), r[15:0], r[31] ? 2'b01 : 2'b10);
    end
    for (int i = 0; i < RAM_TESTS; i++) begin
      r = lcg();
      read_check(1'b0, alias_of(addrs[i], r), "wb_dat_o ram");
    end

    // Switches and LEDs at IO 0xf100
    @(negedge clk);
    r = lcg();
    sw = r[7:0];
    read_check(1'b1, 19'h7880, "wb_dat_o switches");
    r = lcg();
    write_word(1'b1, 19'h7881, r[15:0], 2'b11);
    check("leds_o", data_t'(led_model), data_t'(leds));
    read_check(1'b1, 19'h7881, "wb_dat_o leds");
    write_word(1'b1, 19'h7881, r[31:16], 2'b10);
    check("leds_o", data_t'(led_model), data_t'(leds));
    r = lcg();
    write_word(1'b0, 19'h7881, r[15:0], 2'b11);  // Memory space, same offset
    check("leds_o", data_t'(led_model), data_t'(leds));
    read_check(1'b0, 19'h7881, "wb_dat_o ram at gpio offset");

    // Unmapped IO 0x300
    r = lcg();
    write_word(1'b0, 19'h0180, r[15:0], 2'b11);
    write_word(1'b1, 19'h0180, r[31:16], 2'b11);
    read_check(1'b1, 19'h0180, "wb_dat_o default slave");
    read_check(1'b0, 19'h0180, "wb_dat_o ram under io 0x300");
    check("leds_o", data_t'(led_model), data_t'(leds));

    // External lines 5 and 2
    check("intr_o", '0, data_t'(intr));
    @(negedge clk);
    irq = 7'b001_0010;
    @(negedge clk);
    irq = '0;
    n = 0;
    while (!intr && n < IRQ_WAIT) begin
      @(negedge clk);
      n++;
    end
    if (!intr) report_timeout("intr_o did not rise after the irq_i pulses");
    ack_interrupt(v);
    check("wb_dat_o vector", 16'h000a, v);
    ack_interrupt(v);
    check("wb_dat_o vector", 16'h000d, v);
    check("intr_o", '0, data_t'(intr));

    // Timer at IO 0x40
    write_word(1'b1, 19'h0020, 16'd5, 2'b11);
    write_word(1'b1, 19'h0021, 16'h0001, 2'b01);
    n = 0;
    while (!intr && n < IRQ_WAIT) begin
      @(negedge clk);
      n++;
    end
    if (!intr) report_timeout("timer interrupt did not arrive");
    ack_interrupt(v);
    check("wb_dat_o timer vector", 16'h0008, v);
    write_word(1'b1, 19'h0021, 16'h0000, 2'b01);
    n = 0;
    while (intr && n < IRQ_LINES) begin  // Late timer edge may still be pending
      ack_interrupt(v);
      check("wb_dat_o timer vector", 16'h0008, v);
      n++;
    end
    if (intr) report_timeout("intr_o stays high after the timer was stopped");

    // Pushbutton NMI
    check("nmi_o", '0, data_t'(nmi));
    @(negedge clk);
    key = 1'b0;
    n = 0;
    while (!nmi && n < IRQ_WAIT) begin
      @(negedge clk);
      n++;
    end
    if (!nmi) report_timeout("nmi_o did not rise after the key press");
    @(negedge clk);
    nmia = 1'b1;
    #(CLK_HALF / 5);
    check("wb_dat_o nmi vector", 16'h0002, wb_dat_r);
    @(negedge clk);
    nmia = 1'b0;
    key  = 1'b1;
    check("nmi_o", '0, data_t'(nmi));

    n = 0;
    while (got_q.size() > 0 && n < 4) begin
      @(negedge clk);
      n++;
    end
    if (got_q.size() > 0) report_timeout("read results were never compared");
    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- kotku_lite.sv
// Reduced PC system fabric
`timescale 1ns/1ns
`default_nettype none

module kotku_lite import soc_bus_pkg::*, soc_irq_pkg::*; (
  input  logic             clk,
  input  logic             rst_lck,
  // CPU bus port
  input  word_addr_t       wb_adr_i,
  input  logic             wb_tga_i,
  input  data_t            wb_dat_i,
  output data_t            wb_dat_o,
  input  logic [SEL_W-1:0] wb_sel_i,
  input  logic             wb_we_i,
  input  logic             wb_cyc_i,
  input  logic             wb_stb_i,
  output logic             wb_ack_o,
  // Interrupts
  input  logic [6:0]       irq_i,  // Lines 7:1
  output logic             intr_o,
  input  logic             inta_i,
  output logic             nmi_o,
  input  logic             nmia_i,
  // Board IO
  input  logic [7:0]       sw_i,
  input  logic             key_i,
  output logic [LED_W-1:0] leds_o,
  output logic             cpu_rst_o
);

  logic                 rst;
  logic                 timer_irq;
  logic [IRQ_LINES-1:0] intv;
  irq_id_t              iid;

  wb_bus_if cpu_bus ();
  wb_bus_if gpio_bus ();
  wb_bus_if timer_bus ();
  wb_bus_if ram_bus ();

  assign cpu_bus.adr   = wb_adr_i;
  assign cpu_bus.tga   = wb_tga_i;
  assign cpu_bus.dat_w = wb_dat_i;
  assign cpu_bus.sel   = wb_sel_i;
  assign cpu_bus.we    = wb_we_i;
  assign cpu_bus.cyc   = wb_cyc_i;
  assign cpu_bus.stb   = wb_stb_i;
  assign wb_ack_o      = cpu_bus.ack;
  assign cpu_rst_o     = rst;

  always_comb begin
    intv            = {irq_i, 1'b0};
    intv[TIMER_IRQ] = timer_irq;
  end

  // Vector fetch overrides bus data
  assign wb_dat_o = nmia_i ? NMI_VECTOR :
                    inta_i ? IRQ_VECTOR_BASE + DATA_W'(iid) :
                             cpu_bus.dat_r;

  reset_debounce rst_i (.clk, .rst_lck, .sys_rst_o(rst));

  wb_switch switch_i (
    .clk, .rst,
    .cpu   (cpu_bus),
    .gpio  (gpio_bus),
    .timer (timer_bus),
    .ram   (ram_bus)
  );

  base_ram ram_i (.clk, .rst, .bus(ram_bus));

  sw_leds gpio_i (
    .clk, .rst,
    .bus    (gpio_bus),
    .sw_i, .key_i, .leds_o, .nmia_i, .nmi_o
  );

  pit_timer timer_i (.clk, .rst, .bus(timer_bus), .irq_o(timer_irq));

  simple_pic pic_i (.clk, .rst, .intv_i(intv), .inta_i, .intr_o, .iid_o(iid));

endmodule

`default_nettype wire

//--- simple_pic.sv
// Edge-triggered priority interrupt controller
`timescale 1ns/1ns
`default_nettype none

module simple_pic import soc_irq_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [IRQ_LINES-1:0] intv_i,
  input  logic                 inta_i,
  output logic                 intr_o,
  output irq_id_t              iid_o
);

  logic [IRQ_LINES-1:0] intv_q;
  logic [IRQ_LINES-1:0] pending_q;
  logic [IRQ_LINES-1:0] rise;
  logic [IRQ_LINES-1:0] clr;

  assign rise   = intv_i & ~intv_q;
  assign intr_o = |pending_q;

  // Lowest pending line has priority
  always_comb begin
    iid_o = '0;
    for (int i = IRQ_LINES - 1; i >= 0; i--) begin
      if (pending_q[i]) iid_o = irq_id_t'(i);
    end
  end

  always_comb begin
    clr = '0;
    if (inta_i) clr[iid_o] = 1'b1;  // Acknowledge retires the served line
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      intv_q    <= '0;
      pending_q <= '0;
    end else begin
      intv_q    <= intv_i;
      pending_q <= (pending_q & ~clr) | rise;  // Fresh edge survives an ack
    end
  end

endmodule

`default_nettype wire

//--- pit_timer.sv
// Periodic interval timer
`timescale 1ns/1ns
`default_nettype none

module pit_timer import soc_bus_pkg::*, soc_irq_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  wb_bus_if.slave bus,
  output logic    irq_o
);

  data_t reload_q;
  data_t reload_n;
  data_t count_q;
  logic  en_q;
  logic  run;
  logic  wr_stb;
  logic  reload_wr;
  logic  ctrl_wr;

  assign wr_stb    = bus.cyc && bus.stb && bus.ack && bus.we;
  assign reload_wr = wr_stb && (bus.adr[0] == TIMER_RELOAD_OFS);
  assign ctrl_wr   = wr_stb && (bus.adr[0] == TIMER_CTRL_OFS) && bus.sel[0];
  assign run       = en_q && (reload_q != '0);

  always_comb begin
    reload_n = reload_q;
    for (int b = 0; b < SEL_W; b++) begin
      if (bus.sel[b]) reload_n[b*8 +: 8] = bus.dat_w[b*8 +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bus.ack  <= 1'b0;
      reload_q <= '0;
      count_q  <= '0;
      en_q     <= 1'b0;
      irq_o    <= 1'b0;
    end else begin
      bus.ack <= bus.cyc && bus.stb && !bus.ack;
      irq_o   <= run && (count_q == '0) && !ctrl_wr;  // One cycle per wrap
      if (reload_wr) begin
        reload_q <= reload_n;
        count_q  <= reload_n;  // Restart the period
      end else if (run) begin
        count_q <= (count_q == '0) ? reload_q : count_q - 1'b1;
      end
      if (ctrl_wr) en_q <= bus.dat_w[0];
    end
  end

  always_ff @(posedge clk) begin
    if (bus.adr[0] == TIMER_RELOAD_OFS) bus.dat_r <= count_q;  // Live count
    else                                bus.dat_r <= DATA_W'(en_q);
  end

  a_irq_needs_en: assert property (@(posedge clk) disable iff (rst) irq_o |-> en_q);

endmodule

`default_nettype wire

//--- sw_leds.sv
// Switches, LEDs and pushbutton NMI
`timescale 1ns/1ns
`default_nettype none

module sw_leds import soc_bus_pkg::*, soc_irq_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  wb_bus_if.slave          bus,
  input  logic [7:0]       sw_i,
  input  logic             key_i,
  output logic [LED_W-1:0] leds_o,
  input  logic             nmia_i,
  output logic             nmi_o
);

  logic [LED_W-1:0] leds_q;
  logic [2:0]       key_q;  // Two sync stages plus history
  logic             key_fall;
  logic             wr_stb;

  assign wr_stb   = bus.cyc && bus.stb && bus.ack && bus.we;
  assign key_fall = key_q[2] && !key_q[1];  // Button is active low
  assign leds_o   = leds_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      bus.ack <= 1'b0;
      leds_q  <= '0;
      key_q   <= '1;
      nmi_o   <= 1'b0;
    end else begin
      bus.ack <= bus.cyc && bus.stb && !bus.ack;
      key_q   <= {key_q[1:0], key_i};
      if (wr_stb && bus.adr[0] == GPIO_LED_OFS) begin
        if (bus.sel[0]) leds_q[7:0]       <= bus.dat_w[7:0];
        if (bus.sel[1]) leds_q[LED_W-1:8] <= bus.dat_w[LED_W-1:8];
      end
      if (key_fall)    nmi_o <= 1'b1;  // New press wins over ack
      else if (nmia_i) nmi_o <= 1'b0;
    end
  end

  // Switch word is read only
  always_ff @(posedge clk) begin
    if (bus.adr[0] == GPIO_SW_OFS) bus.dat_r <= DATA_W'(sw_i);
    else                           bus.dat_r <= DATA_W'(leds_q);
  end

endmodule

`default_nettype wire

//--- base_ram.sv
// Base RAM with byte lanes
`timescale 1ns/1ns
`default_nettype none

module base_ram import soc_bus_pkg::*; (
  input logic     clk,
  input logic     rst,
  wb_bus_if.slave bus
);

  data_t             mem [RAM_WORDS];
  logic [RAM_AW-1:0] idx;
  logic              wr_stb;

  assign idx    = bus.adr[RAM_AW-1:0];  // Upper address bits alias
  assign wr_stb = bus.cyc && bus.stb && bus.ack && bus.we;

  always_ff @(posedge clk) begin
    if (rst) bus.ack <= 1'b0;
    else     bus.ack <= bus.cyc && bus.stb && !bus.ack;
  end

  // Write lands as the ack cycle ends
  always_ff @(posedge clk) begin
    if (wr_stb) begin
      for (int b = 0; b < SEL_W; b++) begin
        if (bus.sel[b]) mem[idx][b*8 +: 8] <= bus.dat_w[b*8 +: 8];
      end
    end
    bus.dat_r <= mem[idx];
  end

endmodule

`default_nettype wire

//--- wb_switch.sv
// Bus address switch
`timescale 1ns/1ns
`default_nettype none

module wb_switch import soc_bus_pkg::*; (
  input logic      clk,
  input logic      rst,
  wb_bus_if.slave  cpu,
  wb_bus_if.master gpio,
  wb_bus_if.master timer,
  wb_bus_if.master ram
);

  logic [ADDR_W:0] tadr;
  slave_e          dec;
  slave_e          sel_q;
  logic            active_q;  // Select latched for the current cycle
  logic            hit_gpio;
  logic            hit_timer;
  logic            hit_ram;
  logic            hit_def;

  assign tadr = {cpu.tga, cpu.adr};

  // First match in table order wins
  always_comb begin
    if ((tadr & GPIO_MASK) == GPIO_ADDR)        dec = SLV_GPIO;
    else if ((tadr & TIMER_MASK) == TIMER_ADDR) dec = SLV_TIMER;
    else if ((tadr & RAM_MASK) == RAM_ADDR)     dec = SLV_RAM;
    else                                        dec = SLV_DEFAULT;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      active_q <= 1'b0;
      sel_q    <= SLV_DEFAULT;
    end else if (!active_q) begin
      if (cpu.cyc && cpu.stb) begin
        active_q <= 1'b1;
        sel_q    <= dec;
      end
    end else if (cpu.ack || !cpu.cyc) begin
      active_q <= 1'b0;  // Re-decode on the next request
    end
  end

  assign hit_gpio  = active_q && (sel_q == SLV_GPIO);
  assign hit_timer = active_q && (sel_q == SLV_TIMER);
  assign hit_ram   = active_q && (sel_q == SLV_RAM);
  assign hit_def   = active_q && (sel_q == SLV_DEFAULT);

  // Request fan-out
  assign gpio.adr   = cpu.adr;
  assign gpio.tga   = cpu.tga;
  assign gpio.dat_w = cpu.dat_w;
  assign gpio.sel   = cpu.sel;
  assign gpio.we    = cpu.we;
  assign gpio.cyc   = cpu.cyc && hit_gpio;
  assign gpio.stb   = cpu.stb && hit_gpio;

  assign timer.adr   = cpu.adr;
  assign timer.tga   = cpu.tga;
  assign timer.dat_w = cpu.dat_w;
  assign timer.sel   = cpu.sel;
  assign timer.we    = cpu.we;
  assign timer.cyc   = cpu.cyc && hit_timer;
  assign timer.stb   = cpu.stb && hit_timer;

  assign ram.adr   = cpu.adr;
  assign ram.tga   = cpu.tga;
  assign ram.dat_w = cpu.dat_w;
  assign ram.sel   = cpu.sel;
  assign ram.we    = cpu.we;
  assign ram.cyc   = cpu.cyc && hit_ram;
  assign ram.stb   = cpu.stb && hit_ram;

  // Default slave acks at once with zero data
  assign cpu.ack = (hit_gpio && gpio.ack) || (hit_timer && timer.ack) ||
                   (hit_ram && ram.ack) || (hit_def && cpu.cyc && cpu.stb);

  always_comb begin
    case (sel_q)
      SLV_GPIO:  cpu.dat_r = gpio.dat_r;
      SLV_TIMER: cpu.dat_r = timer.dat_r;
      SLV_RAM:   cpu.dat_r = ram.dat_r;
      default:   cpu.dat_r = '0;
    endcase
  end

  // No slave strobed or still acking while another is served
  a_one_stb: assert property (@(posedge clk) disable iff (rst)
    $onehot0({gpio.stb || gpio.ack, timer.stb || timer.ack, ram.stb || ram.ack}));

endmodule

`default_nettype wire

//--- reset_debounce.sv
// Power-on and debounce reset
`timescale 1ns/1ns
`default_nettype none

module reset_debounce import soc_irq_pkg::*; (
  input  logic clk,
  input  logic rst_lck,
  output logic sys_rst_o
);

  logic [DEBOUNCE_W-1:0] cnt_q;

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      cnt_q     <= DEBOUNCE_W'(DEBOUNCE_CYCLES); // Reload while held
      sys_rst_o <= 1'b1;
    end else begin
      if (cnt_q != '0) cnt_q <= cnt_q - 1'b1;
      sys_rst_o <= (cnt_q != '0);  // Hold until count drains
    end
  end

  // System reset follows the external reset by one edge
  a_rst_follows: assert property (@(posedge clk) !rst_lck |=> sys_rst_o);

endmodule

`default_nettype wire

//--- wb_bus_if.sv
// Wishbone-like bus interface
`timescale 1ns/1ns
`default_nettype none

interface wb_bus_if import soc_bus_pkg::*; ();

  word_addr_t       adr;
  logic             tga;  // High for IO space
  data_t            dat_w;
  data_t            dat_r;
  logic [SEL_W-1:0] sel;
  logic             we;
  logic             cyc;
  logic             stb;
  logic             ack;

  modport master (
    output adr, tga, dat_w, sel, we, cyc, stb,
    input  dat_r, ack
  );

  modport slave (
    input  adr, tga, dat_w, sel, we, cyc, stb,
    output dat_r, ack
  );

endinterface

`default_nettype wire

//--- soc_irq_pkg.sv
// Interrupt and peripheral definitions
`default_nettype none

package soc_irq_pkg;

  localparam int IRQ_LINES = 8;

  typedef logic [2:0] irq_id_t;

  localparam logic [15:0] IRQ_VECTOR_BASE = 16'h0008; // Vector is base plus line
  localparam logic [15:0] NMI_VECTOR      = 16'h0002;
  localparam irq_id_t     TIMER_IRQ       = 3'd0;

  // Word offsets inside each IO window
  localparam logic TIMER_RELOAD_OFS = 1'b0;
  localparam logic TIMER_CTRL_OFS   = 1'b1;
  localparam logic GPIO_SW_OFS      = 1'b0;
  localparam logic GPIO_LED_OFS     = 1'b1;

  localparam int LED_W = 14;

  // Reset hold after rst_lck release
  localparam int DEBOUNCE_CYCLES = 16;
  localparam int DEBOUNCE_W      = $clog2(DEBOUNCE_CYCLES + 1);

endpackage

`default_nettype wire

//--- soc_bus_pkg.sv
// System bus definitions
`default_nettype none

package soc_bus_pkg;

  localparam int DATA_W = 16;
  localparam int ADDR_W = 19;  // Word address, byte bits 19:1
  localparam int SEL_W  = 2;

  typedef logic [ADDR_W-1:0] word_addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // Slaves in decode priority order
  typedef enum logic [1:0] {
    SLV_GPIO,
    SLV_TIMER,
    SLV_RAM,
    SLV_DEFAULT
  } slave_e;

  // Address map as {tga, adr[19:1]}
  localparam logic [ADDR_W:0] GPIO_ADDR  = 20'b1_0000_1111_0001_0000_000; // io 0xf100 - 0xf103
  localparam logic [ADDR_W:0] GPIO_MASK  = 20'b1_0000_1111_1111_1111_110;
  localparam logic [ADDR_W:0] TIMER_ADDR = 20'b1_0000_0000_0000_0100_000; // io 0x40 - 0x43
  localparam logic [ADDR_W:0] TIMER_MASK = 20'b1_0000_1111_1111_1111_110;
  localparam logic [ADDR_W:0] RAM_ADDR   = 20'b0_0000_0000_0000_0000_000; // Any memory cycle
  localparam logic [ADDR_W:0] RAM_MASK   = 20'b1_0000_0000_0000_0000_000;

  // Base RAM depth, addresses alias above it
  localparam int RAM_WORDS = 1024;
  localparam int RAM_AW    = $clog2(RAM_WORDS);

endpackage

`default_nettype wire
